// File: dv/tb_mmu.sv
`timescale 1ns/1ns

module tb_mmu;

    localparam logic [63:0] ptbr_value = 64'h0000_0000_0010_0000;
    localparam logic [63:0] va_a = 64'h0000_7f12_3456_7abc;
    localparam logic [63:0] va_d = 64'h0000_0000_0040_1008;
    // nine walks of up to about 70 cycles plus the aux hold and a wide margin
    localparam int timeout_cycles = 4000;

    logic        clk = 1'b0;
    logic        reset;
    logic        translate;
    logic        flush;
    logic [63:0] virt_addr;
    logic [63:0] ptbr;
    logic        ready;
    logic [63:0] phy_addr;
    logic        bus_reqcyc;
    logic [63:0] bus_req;
    logic [12:0] bus_reqtag;
    logic        bus_respcyc = 1'b0;
    logic [63:0] bus_resp = '0;
    logic        bus_respack;
    logic        aux_busy;
    logic        aux_grant;
    logic        aux_reqcyc;
    logic [63:0] aux_req;
    logic [12:0] aux_reqtag;
    logic        aux_respack;
    logic        aux_respcyc;
    logic [63:0] aux_resp;

    logic [63:0] mem [logic [63:0]];  // sparse memory of 8-byte words by byte address
    logic [63:0] next_table;
    logic [63:0] line_addr;
    integer      seed = 32'hd306;
    int          wait_left;
    int          beat_num;
    bit          active = 1'b0;
    int          req_count = 0;
    int          checks = 0;
    int          errors = 0;
    int          cycle_count = 0;

    mmu_top DUT (.*);

    initial
    begin
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= timeout_cycles)
        begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic logic [63:0] read_word(input logic [63:0] addr);
        if (mem.exists(addr))
            return mem[addr];
        return ~addr;  // words outside the tables read back as their own address inverted
    endfunction

    function automatic logic [63:0] entry_slot(input logic [63:0] base, input logic [63:0] va,
                                               input int lvl);
        return base + ((va >> (39 - 9 * lvl)) & 64'h1ff) * 64'd8;
    endfunction

    function automatic void map_page(input logic [63:0] va, input logic [63:0] page);
        logic [63:0] base;
        logic [63:0] slot;
        base = ptbr_value;
        for (int lvl = 0; lvl < 3; lvl++)
        begin
            slot = entry_slot(base, va, lvl);
            if (!mem.exists(slot))
            begin
                mem[slot] = ((next_table >> 12) << 10) | 64'h0cf;  // flag bits below bit 10
                next_table = next_table + 64'h1000;
            end
            base = (mem[slot] >> 10) << 12;
        end
        mem[entry_slot(base, va, 3)] = ((page >> 12) << 10) | 64'h3c1;
    endfunction

    function automatic logic [63:0] expected_pa(input logic [63:0] va);
        logic [63:0] base;
        base = ptbr_value;
        for (int lvl = 0; lvl < 4; lvl++)
            base = (read_word(entry_slot(base, va, lvl)) >> 10) << 12;
        return base | {52'd0, va[11:0]};
    endfunction

    function automatic logic [63:0] repl_va(input int n);
        // each page differs in its level 1, 2 and 3 indices
        return 64'h0000_2a00_0000_0000 + 64'(n) * 64'h0000_0000_4020_1000 + 64'(n) * 64'h10;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] want);
        checks++;
        assert (got === want)
        else
        begin
            errors++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    // each request gets one read burst whose first beat comes 1 to 5 cycles after reqcyc
    always @(negedge clk)
    begin
        if (!reset)
        begin
            if (!active)
                check_value("bus_respack outside a burst", 64'(bus_respack), 64'd0);
            else if (beat_num > 0)
                check_value("bus_respack during a burst", 64'(bus_respack), 64'd1);
            if (bus_respcyc)
                check_value("aux_respcyc during a walker burst", 64'(aux_respcyc), 64'd0);
        end
        bus_respcyc = 1'b0;
        if (active)
        begin
            if (wait_left > 1)
                wait_left--;
            else
            begin
                bus_respcyc = 1'b1;
                bus_resp = read_word(line_addr + 64'(beat_num) * 64'd8);
                beat_num++;
                active = (beat_num < 8);
            end
        end
        else if (bus_reqcyc)
        begin
            req_count++;
            check_value("request line offset", {58'd0, bus_req[5:0]}, 64'd0);
            check_value("request tag", {51'd0, bus_reqtag}, {51'd0, 13'h1100});  // read, memory
            line_addr = bus_req;
            beat_num = 0;
            wait_left = 1 + int'($unsigned($random(seed)) % 32'd5);
            active = 1'b1;
        end
    end

    task automatic pulse_translate(input logic [63:0] va);
        virt_addr = va;
        translate = 1'b1;
        @(negedge clk);
        translate = 1'b0;
    endtask

    task automatic wait_ready(output int cycles);
        cycles = 1;
        while (!ready)
        begin
            @(negedge clk);
            cycles++;
        end
    endtask

    // virt_addr is held until ready since the walker takes it when the walk starts
    task automatic translate_page(input logic [63:0] va, output int cycles, output int reqs);
        int reqs_before;
        reqs_before = req_count;
        pulse_translate(va);
        wait_ready(cycles);
        reqs = req_count - reqs_before;
        check_value("phy_addr", phy_addr, expected_pa(va));
    endtask

    task automatic apply_flush();
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        @(negedge clk);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - errors_before);
    endtask

    task automatic test_miss_walk();
        int errs;
        int cycles;
        int reqs;
        errs = errors;
        translate_page(va_a, cycles, reqs);
        check_value("bus requests on a miss", 64'(reqs), 64'd4);
        finish_test("miss walk", errs);
    endtask

    task automatic test_hit();
        int errs;
        int cycles;
        int reqs;
        errs = errors;
        translate_page({va_a[63:12], 12'h123}, cycles, reqs);
        check_value("hit latency", 64'(cycles), 64'd1);
        check_value("bus requests on a hit", 64'(reqs), 64'd0);
        finish_test("hit", errs);
    endtask

    task automatic test_flush();
        int errs;
        int cycles;
        int reqs;
        errs = errors;
        apply_flush();
        translate_page(va_a, cycles, reqs);
        check_value("bus requests after flush", 64'(reqs), 64'd4);
        finish_test("flush", errs);
    endtask

    task automatic test_arbitration();
        int errs;
        int cycles;
        int reqs_before;
        int tries;
        errs = errors;
        reqs_before = req_count;
        aux_busy = 1'b1;
        tries = 0;
        while (!aux_grant && tries < 8)
        begin
            @(negedge clk);
            tries++;
        end
        check_value("aux_grant while aux is busy", 64'(aux_grant), 64'd1);
        pulse_translate(va_d);
        repeat (12)
        begin
            check_value("bus_reqcyc while aux owns the bus", 64'(bus_reqcyc), 64'd0);
            check_value("aux_grant while aux holds busy", 64'(aux_grant), 64'd1);
            check_value("aux_resp while aux owns the bus", aux_resp, bus_resp);
            @(negedge clk);
        end
        aux_busy = 1'b0;
        @(negedge clk);
        check_value("aux_grant after busy drops", 64'(aux_grant), 64'd0);
        wait_ready(cycles);
        check_value("phy_addr after arbitration", phy_addr, expected_pa(va_d));
        check_value("bus requests after arbitration", 64'(req_count - reqs_before), 64'd4);
        finish_test("arbitration", errs);
    endtask

    task automatic test_replacement();
        int errs;
        int cycles;
        int reqs;
        errs = errors;
        apply_flush();
        for (int n = 0; n < 5; n++)
        begin
            translate_page(repl_va(n), cycles, reqs);
            check_value("bus requests on a new page", 64'(reqs), 64'd4);
        end
        translate_page(repl_va(0), cycles, reqs);  // evicted by the fifth page
        check_value("bus requests on the evicted page", 64'(reqs), 64'd4);
        translate_page(repl_va(4) + 64'h0a8, cycles, reqs);
        check_value("hit latency on a kept page", 64'(cycles), 64'd1);
        check_value("bus requests on a kept page", 64'(reqs), 64'd0);
        finish_test("replacement", errs);
    endtask

    initial
    begin
        reset = 1'b1;
        translate = 1'b0;
        flush = 1'b0;
        virt_addr = '0;
        ptbr = ptbr_value;
        aux_busy = 1'b0;
        aux_reqcyc = 1'b0;
        aux_req = '0;
        aux_reqtag = '0;
        aux_respack = 1'b0;
        next_table = 64'h0000_0000_0020_0000;
        map_page(va_a, 64'h000a_bcde_f012_3000);
        map_page(va_d, 64'h0000_0000_8000_0000);
        for (int n = 0; n < 5; n++)
            map_page(repl_va(n), 64'h0000_0123_0000_0000 + 64'(n) * 64'h0011_1000);
        repeat (3) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        test_miss_walk();
        test_hit();
        test_flush();
        test_arbitration();
        test_replacement();
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: hw/bus_arbiter.sv
`timescale 1ns/1ns

module bus_arbiter
(
    input  logic                                   clk,
    input  logic                                   reset,
    sys_bus_if.slave                               walker,
    sys_bus_if.slave                               aux,
    output logic                                   bus_reqcyc,
    output logic [sys_bus_pkg::bus_data_width-1:0] bus_req,
    output logic [sys_bus_pkg::bus_tag_width-1:0]  bus_reqtag,
    input  logic                                   bus_respcyc,
    input  logic [sys_bus_pkg::bus_data_width-1:0] bus_resp,
    output logic                                   bus_respack
);

    logic owned;
    logic owner;      // set when aux holds the bus
    logic aux_first;  // aux was granted least recently and wins a tie
    logic owner_busy;
    logic pick;

    assign owner_busy = owner ? aux.busy : walker.busy;
    assign pick = (walker.busy && aux.busy) ? aux_first : aux.busy;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            owned <= 1'b0;
            owner <= 1'b0;
            aux_first <= 1'b0;
        end
        else if (owned)
        begin
            if (!owner_busy)
                owned <= 1'b0;
        end
        else if (walker.busy || aux.busy)
        begin
            owned <= 1'b1;
            owner <= pick;
            aux_first <= !pick;
        end
    end

    assign walker.grant = owned && !owner;
    assign aux.grant = owned && owner;

    always_comb
    begin
        bus_reqcyc = 1'b0;
        bus_req = '0;
        bus_reqtag = '0;
        bus_respack = 1'b0;
        if (walker.grant)
        begin
            bus_reqcyc = walker.reqcyc;
            bus_req = walker.req;
            bus_reqtag = walker.reqtag;
            bus_respack = walker.respack;
        end
        else if (aux.grant)
        begin
            bus_reqcyc = aux.reqcyc;
            bus_req = aux.req;
            bus_reqtag = aux.reqtag;
            bus_respack = aux.respack;
        end
    end

    assign walker.respcyc = bus_respcyc && walker.grant;
    assign walker.resp = walker.grant ? bus_resp : '0;
    assign aux.respcyc = bus_respcyc && aux.grant;
    assign aux.resp = aux.grant ? bus_resp : '0;

    assert property (@(posedge clk) disable iff (reset) !(walker.grant && aux.grant));

endmodule

// File: hw/mmu_top.sv
`timescale 1ns/1ns

module mmu_top
(
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   translate,
    input  logic                                   flush,
    input  logic [sys_bus_pkg::bus_data_width-1:0] virt_addr,
    input  logic [sys_bus_pkg::bus_data_width-1:0] ptbr,
    output logic                                   ready,
    output logic [sys_bus_pkg::bus_data_width-1:0] phy_addr,
    output logic                                   bus_reqcyc,
    output logic [sys_bus_pkg::bus_data_width-1:0] bus_req,
    output logic [sys_bus_pkg::bus_tag_width-1:0]  bus_reqtag,
    input  logic                                   bus_respcyc,
    input  logic [sys_bus_pkg::bus_data_width-1:0] bus_resp,
    output logic                                   bus_respack,
    input  logic                                   aux_busy,
    output logic                                   aux_grant,
    input  logic                                   aux_reqcyc,
    input  logic [sys_bus_pkg::bus_data_width-1:0] aux_req,
    input  logic [sys_bus_pkg::bus_tag_width-1:0]  aux_reqtag,
    input  logic                                   aux_respack,
    output logic                                   aux_respcyc,
    output logic [sys_bus_pkg::bus_data_width-1:0] aux_resp
);

    logic                                   walk_enable;
    logic                                   walk_ready;
    logic [sys_bus_pkg::bus_data_width-1:0] walk_phy_addr;

    sys_bus_if walker_bus ();
    sys_bus_if aux_bus ();

    // the external master drives its half of the bundle from the top ports
    assign aux_bus.busy = aux_busy;
    assign aux_bus.reqcyc = aux_reqcyc;
    assign aux_bus.req = aux_req;
    assign aux_bus.reqtag = aux_reqtag;
    assign aux_bus.respack = aux_respack;
    assign aux_grant = aux_bus.grant;
    assign aux_respcyc = aux_bus.respcyc;
    assign aux_resp = aux_bus.resp;

    tlb u_tlb
    (
        .clk           (clk),
        .reset         (reset),
        .translate     (translate),
        .flush         (flush),
        .virt_addr     (virt_addr),
        .ready         (ready),
        .phy_addr      (phy_addr),
        .walk_enable   (walk_enable),
        .walk_ready    (walk_ready),
        .walk_phy_addr (walk_phy_addr)
    );

    page_walker u_page_walker
    (
        .clk       (clk),
        .reset     (reset),
        .enable    (walk_enable),
        .ptbr      (ptbr),
        .virt_addr (virt_addr),
        .ready     (walk_ready),
        .phy_addr  (walk_phy_addr),
        .bus       (walker_bus.master)
    );

    bus_arbiter u_bus_arbiter
    (
        .clk         (clk),
        .reset       (reset),
        .walker      (walker_bus.slave),
        .aux         (aux_bus.slave),
        .bus_reqcyc  (bus_reqcyc),
        .bus_req     (bus_req),
        .bus_reqtag  (bus_reqtag),
        .bus_respcyc (bus_respcyc),
        .bus_resp    (bus_resp),
        .bus_respack (bus_respack)
    );

endmodule

// File: hw/page_walker.sv
`timescale 1ns/1ns

module page_walker
(
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   enable,
    input  logic [sys_bus_pkg::bus_data_width-1:0] ptbr,
    input  logic [sys_bus_pkg::bus_data_width-1:0] virt_addr,
    output logic                                   ready,
    output logic [sys_bus_pkg::bus_data_width-1:0] phy_addr,
    sys_bus_if.master                              bus
);

    typedef enum logic [2:0] {
        st_reset,
        st_begin,
        st_req,
        st_wait,
        st_resp,
        st_ready
    } state_t;

    state_t state;
    state_t next_state;

    logic [vm_pkg::level_width-1:0]           level;
    logic [sys_bus_pkg::beat_index_width-1:0] beat;
    logic [sys_bus_pkg::bus_data_width-1:0]   va_q;
    logic [sys_bus_pkg::bus_data_width-1:0]   table_addr;  // entry address for this level
    logic [sys_bus_pkg::bus_data_width-1:0]   pte_q;
    logic [sys_bus_pkg::bus_data_width-1:0]   entry;
    logic                                     start;
    logic                                     beat_valid;
    logic                                     entry_beat;
    logic                                     burst_done;
    logic                                     last_level;

    function automatic logic [vm_pkg::vpn_width-1:0] vpn_field
    (
        input logic [sys_bus_pkg::bus_data_width-1:0] va,
        input logic [vm_pkg::level_width-1:0]         lvl
    );
        int unsigned                            lsb;
        logic [sys_bus_pkg::bus_data_width-1:0] shifted;
        lsb = vm_pkg::va_width - vm_pkg::vpn_width * (int'(lvl) + 1);
        shifted = va >> lsb;
        vpn_field = shifted[vm_pkg::vpn_width-1:0];
    endfunction

    function automatic logic [sys_bus_pkg::bus_data_width-1:0] page_base
    (
        input logic [sys_bus_pkg::bus_data_width-1:0] pte
    );
        logic [sys_bus_pkg::bus_data_width-1:0] ppn;
        ppn = pte >> vm_pkg::pte_ppn_lsb;
        page_base = ppn << vm_pkg::page_offset_width;
    endfunction

    function automatic logic [sys_bus_pkg::bus_data_width-1:0] entry_addr
    (
        input logic [sys_bus_pkg::bus_data_width-1:0] base,
        input logic [vm_pkg::vpn_width-1:0]           idx
    );
        entry_addr = base + 64'(idx) * 64'(vm_pkg::pte_bytes);
    endfunction

    assign start = enable && (state == st_reset || state == st_ready);
    assign beat_valid = bus.respcyc && (state == st_wait || state == st_resp);
    assign entry_beat = beat_valid && (beat == table_addr[5:3]);
    assign burst_done = beat_valid && (beat == sys_bus_pkg::burst_beats - 1);
    assign last_level = (level == vm_pkg::pt_levels - 1);
    assign entry = entry_beat ? bus.resp : pte_q;  // the wanted beat may also be the last

    always_comb
    begin
        case (state)
            st_reset: next_state = enable ? st_begin : st_reset;
            st_begin: next_state = bus.grant ? st_req : st_begin;
            st_req:   next_state = st_wait;
            st_wait:  next_state = bus.respcyc ? st_resp : st_wait;  // first beat lands here
            st_resp:
            begin
                if (!burst_done)
                    next_state = st_resp;
                else if (last_level)
                    next_state = st_ready;
                else
                    next_state = st_req;
            end
            st_ready: next_state = enable ? st_begin : st_ready;
            default:  next_state = st_reset;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= st_reset;
            level <= '0;
            beat <= '0;
        end
        else
        begin
            state <= next_state;
            if (start)
                level <= '0;
            else if (burst_done && !last_level)
                level <= level + 1'b1;
            if (state == st_req)
                beat <= '0;
            else if (beat_valid)
                beat <= beat + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            va_q <= virt_addr;
            table_addr <= entry_addr(ptbr, vpn_field(virt_addr, '0));
        end
        if (entry_beat)
            pte_q <= bus.resp;
        if (burst_done)
        begin
            if (last_level)
                phy_addr <= page_base(entry) + 64'(va_q[vm_pkg::page_offset_width-1:0]);
            else
                table_addr <= entry_addr(page_base(entry), vpn_field(va_q, level + 1'b1));
        end
    end

    assign ready = (state == st_ready);
    assign bus.busy = (state == st_begin || state == st_req ||
                       state == st_wait || state == st_resp);
    assign bus.reqcyc = (state == st_req);
    assign bus.req = {table_addr[63:6], 6'b000000};  // whole line, entry picked by beat
    assign bus.reqtag = {sys_bus_pkg::sysbus_read, sys_bus_pkg::sysbus_memory, 8'h00};
    assign bus.respack = (state == st_resp);

    // a request always waits for its full burst before the next one
    assert property (@(posedge clk) disable iff (reset) bus.reqcyc |=> !bus.reqcyc);

endmodule

// File: hw/sys_bus_if.sv
`timescale 1ns/1ns

interface sys_bus_if;

    logic                                   reqcyc;
    logic [sys_bus_pkg::bus_data_width-1:0] req;
    logic [sys_bus_pkg::bus_tag_width-1:0]  reqtag;
    logic                                   respack;
    logic                                   busy;     // held high while the master wants the bus
    logic                                   respcyc;
    logic [sys_bus_pkg::bus_data_width-1:0] resp;
    logic                                   grant;

    modport master
    (
        output reqcyc, req, reqtag, respack, busy,
        input  respcyc, resp, grant
    );

    modport slave
    (
        input  reqcyc, req, reqtag, respack, busy,
        output respcyc, resp, grant
    );

endinterface

// File: hw/sys_bus_pkg.sv
package sys_bus_pkg;

    localparam int bus_data_width = 64;
    localparam int bus_tag_width = 13;

    // tag layout: bit 12 is the read flag, bits 11:8 the target kind
    localparam logic [0:0] sysbus_read = 1'b1;
    localparam logic [3:0] sysbus_memory = 4'b0001;

    // every request returns one 64-byte line as 8 beats of 64 bits
    localparam int burst_beats = 8;
    localparam int beat_index_width = 3;

endpackage

// File: hw/tlb.sv
`timescale 1ns/1ns

module tlb
(
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   translate,
    input  logic                                   flush,
    input  logic [sys_bus_pkg::bus_data_width-1:0] virt_addr,
    output logic                                   ready,
    output logic [sys_bus_pkg::bus_data_width-1:0] phy_addr,
    output logic                                   walk_enable,
    input  logic                                   walk_ready,
    input  logic [sys_bus_pkg::bus_data_width-1:0] walk_phy_addr
);

    logic [vm_pkg::tlb_entries-1:0]     valid;
    logic [vm_pkg::vpage_width-1:0]     vpage [vm_pkg::tlb_entries];
    logic [vm_pkg::ppage_width-1:0]     ppage [vm_pkg::tlb_entries];
    logic [vm_pkg::tlb_index_width-1:0] fill_ptr;
    logic [vm_pkg::tlb_index_width-1:0] hit_idx;
    logic [vm_pkg::vpage_width-1:0]     lookup_vpage;
    logic [vm_pkg::vpage_width-1:0]     miss_vpage;
    logic                               hit;
    logic                               walking;
    logic                               walk_done;

    assign lookup_vpage = virt_addr[vm_pkg::va_width-1:vm_pkg::page_offset_width];
    // walker still shows ready from the last walk while enable is high
    assign walk_done = walking && walk_ready && !walk_enable;

    always_comb
    begin
        hit = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < vm_pkg::tlb_entries; i++)
        begin
            if (valid[i] && vpage[i] == lookup_vpage)
            begin
                hit = 1'b1;
                hit_idx = i[vm_pkg::tlb_index_width-1:0];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid <= '0;
            fill_ptr <= '0;
            walking <= 1'b0;
            walk_enable <= 1'b0;
            ready <= 1'b0;
        end
        else
        begin
            ready <= 1'b0;
            walk_enable <= 1'b0;
            if (!walking && translate)
            begin
                ready <= hit;
                walking <= !hit;
                walk_enable <= !hit;
            end
            else if (walk_done)
            begin
                walking <= 1'b0;
                ready <= 1'b1;
                fill_ptr <= fill_ptr + 1'b1;  // round robin replacement
            end
            if (flush)
                valid <= '0;
            else if (walk_done)
                valid[fill_ptr] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!walking && translate)
        begin
            miss_vpage <= lookup_vpage;
            phy_addr <= {ppage[hit_idx], virt_addr[vm_pkg::page_offset_width-1:0]};
        end
        else if (walk_done)
        begin
            vpage[fill_ptr] <= miss_vpage;
            ppage[fill_ptr] <= walk_phy_addr[63:vm_pkg::page_offset_width];
            phy_addr <= walk_phy_addr;
        end
    end

    for (genvar i = 0; i < vm_pkg::tlb_entries; i++)
    begin : g_unique
        for (genvar j = i + 1; j < vm_pkg::tlb_entries; j++)
        begin : g_pair
            // a fill only follows a lookup that missed every valid entry
            assert property (@(posedge clk) disable iff (reset)
                !(valid[i] && valid[j] && vpage[i] == vpage[j]));
        end
    end

endmodule

// File: hw/vm_pkg.sv
package vm_pkg;

    localparam int pt_levels = 4;
    localparam int level_width = $clog2(pt_levels);

    // level 0 indexes va bits 47:39, level 3 bits 20:12
    localparam int vpn_width = 9;
    localparam int va_width = 48;
    localparam int page_offset_width = 12;

    localparam int vpage_width = va_width - page_offset_width;
    localparam int ppage_width = sys_bus_pkg::bus_data_width - page_offset_width;

    // an entry's page number sits in bits 63:10
    localparam int pte_ppn_lsb = 10;
    localparam int pte_bytes = 8;

    localparam int tlb_entries = 4;
    localparam int tlb_index_width = $clog2(tlb_entries);

endpackage

// File: run.sh
#!/bin/sh
# builds the MMU testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_mmu -o tb_mmu; then
    echo "build failed"
    exit 1
fi

if ! ./obj_dir/tb_mmu > "$log" 2>&1; then
    cat "$log"
    echo "simulation exited with an error"
    exit 1
fi

cat "$log"
if grep -qx "ALL CHECKS PASSED" "$log"; then
    exit 0
fi
exit 1

// File: sim.f
hw/sys_bus_pkg.sv
hw/vm_pkg.sv
hw/sys_bus_if.sv
hw/page_walker.sv
hw/tlb.sv
hw/bus_arbiter.sv
hw/mmu_top.sv
dv/tb_mmu.sv
